// File: source/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Field widths
`define OP_W        6
`define FUNCT_W     6
`define REG_W       5
`define SHAMT_W     5
`define IMM_W       16
`define EXC_CODE_W  5

// Primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_BEQL     6'b010100
`define OP_BNEL     6'b010101
`define OP_BLEZL    6'b010110
`define OP_BGTZL    6'b010111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// SPECIAL funct codes
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_SYSCALL  6'b001100
`define FN_BREAK    6'b001101
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// REGIMM rt codes
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZL    5'b00010
`define RT_BGEZL    5'b00011
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001
`define RT_BLTZALL  5'b10010
`define RT_BGEZALL  5'b10011

// Exception codes
`define EXC_RI      5'd10
`define EXC_BP      5'd9
`define EXC_SYS     5'd8

`define LINK_REG    5'd31

`endif

// File: source/decodePkg.sv
`include "decode_defs.svh"

package decodePkg;

	typedef struct packed {
		logic [`OP_W-1:0]    opcode;
		logic [`REG_W-1:0]   rs;
		logic [`REG_W-1:0]   rt;
		logic [`REG_W-1:0]   rd;
		logic [`SHAMT_W-1:0] shamt;
		logic [`FUNCT_W-1:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [`OP_W-1:0]  opcode;
		logic [`REG_W-1:0] rs;
		logic [`REG_W-1:0] rt;
		logic [`IMM_W-1:0] imm16;
	} iFields_t;

	// Same word, register view or immediate view
	typedef union packed {
		rFields_t r;
		iFields_t i;
	} instrWord_t;

	typedef struct packed {
		logic equal;    // rs == rt
		logic negative; // rs < 0
		logic positive; // rs > 0
	} cmpResult_t;

	typedef enum logic [4:0] {
		aluAdd = 5'd0, aluSub = 5'd1, aluOr = 5'd2, aluAnd = 5'd3,
		aluNor = 5'd4, aluXor = 5'd5, aluSll = 5'd6, aluSrl = 5'd7,
		aluSra = 5'd8, aluSlt = 5'd9, aluSltu = 5'd10, aluAddu = 5'd12,
		aluSubu = 5'd16, aluNone = 5'd31
	} aluOp_t;

	typedef enum logic [1:0] {extZero = 2'd0, extSign = 2'd1, extUpper = 2'd2} extOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic   shiftByShamt;
		extOp_t extOp;
		logic   useImm;
	} aluCtrl_t;

	typedef enum logic [1:0] {destRt = 2'd0, destRd = 2'd1, destLink = 2'd2} destSel_t;

	typedef enum logic [2:0] {
		resHilo = 3'd0, resLui = 3'd1, resAlu = 3'd2, resLink = 3'd3, resMem = 3'd4
	} resultSel_t;

	typedef enum logic [1:0] {hiloLo = 2'd0, hiloHi = 2'd1, hiloMdu = 2'd2} hiloWrSel_t;

	typedef enum logic [1:0] {
		mduMultu = 2'd0, mduMult = 2'd1, mduDivu = 2'd2, mduDiv = 2'd3
	} mduOp_t;

	typedef struct packed {
		logic       rfWr;
		destSel_t   destSel;
		resultSel_t resultSel;
		logic       hiloWr;
		hiloWrSel_t hiloWrSel;
		logic       hiloRdHi;
		logic       hiloBusy; // Any HI/LO access
		logic       mduStart;
		mduOp_t     mduOp;
	} wbCtrl_t;

	typedef enum logic [2:0] {
		memSb = 3'd0, memSh = 3'd1, memSw = 3'd2, memLbu = 3'd3,
		memLb = 3'd4, memLhu = 3'd5, memLh = 3'd6, memLw = 3'd7
	} memSel_t;

	typedef struct packed {
		logic    rd;
		logic    wr;
		memSel_t memSel;
	} memCtrl_t;

	typedef enum logic [2:0] {
		brEq = 3'd0, brNe = 3'd1, brGez = 3'd2, brLtz = 3'd3,
		brLez = 3'd4, brGtz = 3'd5, brNone = 3'd7
	} brCond_t;

	typedef enum logic [1:0] {jumpNone = 2'd0, jumpDirect = 2'd1, jumpReg = 2'd2} jumpKind_t;

	typedef struct packed {
		brCond_t   cond;
		logic      likely;
		jumpKind_t jump;
	} branchClass_t;

	typedef enum logic [1:0] {
		predNone = 2'd0, predRet = 2'd1, predOther = 2'd2, predCall = 2'd3
	} predHint_t;

	typedef enum logic [1:0] {
		npcSeq = 2'd0, npcBranch = 2'd1, npcJump = 2'd2, npcJumpReg = 2'd3
	} npcOp_t;

	typedef struct packed {
		logic                   valid;
		logic [`EXC_CODE_W-1:0] code;
	} excInfo_t;

endpackage

// File: source/aluDecoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module aluDecoder (
	input  decodePkg::instrWord_t instr,
	output decodePkg::aluCtrl_t   aluCtrl
);

	always_comb begin
		aluCtrl.aluOp = decodePkg::aluNone;
		aluCtrl.shiftByShamt = 1'b0;
		aluCtrl.useImm = (instr.r.opcode != `OP_SPECIAL); // Operand B from the immediate
		case (instr.r.opcode)
			`OP_SPECIAL: begin
				case (instr.r.funct)
					`FN_ADD:            aluCtrl.aluOp = decodePkg::aluAdd;
					`FN_ADDU:           aluCtrl.aluOp = decodePkg::aluAddu;
					`FN_SUB:            aluCtrl.aluOp = decodePkg::aluSub;
					`FN_SUBU:           aluCtrl.aluOp = decodePkg::aluSubu;
					`FN_OR:             aluCtrl.aluOp = decodePkg::aluOr;
					`FN_AND:            aluCtrl.aluOp = decodePkg::aluAnd;
					`FN_NOR:            aluCtrl.aluOp = decodePkg::aluNor;
					`FN_XOR:            aluCtrl.aluOp = decodePkg::aluXor;
					`FN_SLL, `FN_SLLV:  aluCtrl.aluOp = decodePkg::aluSll;
					`FN_SRL, `FN_SRLV:  aluCtrl.aluOp = decodePkg::aluSrl;
					`FN_SRA, `FN_SRAV:  aluCtrl.aluOp = decodePkg::aluSra;
					`FN_SLT:            aluCtrl.aluOp = decodePkg::aluSlt;
					`FN_SLTU:           aluCtrl.aluOp = decodePkg::aluSltu;
					default:            aluCtrl.aluOp = decodePkg::aluNone;
				endcase
				// Constant shifts take the amount from shamt
				aluCtrl.shiftByShamt = (instr.r.funct == `FN_SLL) ||
					(instr.r.funct == `FN_SRL) || (instr.r.funct == `FN_SRA);
			end
			`OP_ADDI:  aluCtrl.aluOp = decodePkg::aluAdd;
			`OP_ADDIU: aluCtrl.aluOp = decodePkg::aluAddu;
			`OP_SLTI:  aluCtrl.aluOp = decodePkg::aluSlt;
			`OP_SLTIU: aluCtrl.aluOp = decodePkg::aluSltu;
			`OP_ANDI:  aluCtrl.aluOp = decodePkg::aluAnd;
			`OP_ORI:   aluCtrl.aluOp = decodePkg::aluOr;
			`OP_XORI:  aluCtrl.aluOp = decodePkg::aluXor;
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
			`OP_SB, `OP_SH, `OP_SW:
				aluCtrl.aluOp = decodePkg::aluAddu; // Address offset never traps
			default:   aluCtrl.aluOp = decodePkg::aluNone;
		endcase
	end

	always_comb begin
		case (instr.i.opcode)
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
			`OP_SB, `OP_SH, `OP_SW:
				aluCtrl.extOp = decodePkg::extSign;
			`OP_LUI: aluCtrl.extOp = decodePkg::extUpper; // imm16 into the top half
			default: aluCtrl.extOp = decodePkg::extZero;
		endcase
	end

endmodule

// File: source/resultDecoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module resultDecoder (
	input  decodePkg::instrWord_t instr,
	output decodePkg::wbCtrl_t    wbCtrl
);

	always_comb begin
		wbCtrl.rfWr = 1'b0;
		wbCtrl.destSel = decodePkg::destRt;
		wbCtrl.resultSel = decodePkg::resAlu;
		wbCtrl.hiloWr = 1'b0;
		wbCtrl.hiloWrSel = decodePkg::hiloLo;
		wbCtrl.hiloRdHi = 1'b0;
		wbCtrl.hiloBusy = 1'b0;
		wbCtrl.mduStart = 1'b0;
		wbCtrl.mduOp = decodePkg::mduMultu;
		case (instr.r.opcode)
			`OP_SPECIAL: begin
				wbCtrl.destSel = decodePkg::destRd;
				case (instr.r.funct)
					`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_OR, `FN_AND, `FN_NOR,
					`FN_XOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA,
					`FN_SLLV, `FN_SRLV, `FN_SRAV:
						wbCtrl.rfWr = 1'b1;
					`FN_JALR: begin
						wbCtrl.rfWr = 1'b1;
						wbCtrl.resultSel = decodePkg::resLink; // Return address into rd
					end
					`FN_MFHI, `FN_MFLO: begin
						wbCtrl.rfWr = 1'b1;
						wbCtrl.resultSel = decodePkg::resHilo;
						wbCtrl.hiloRdHi = (instr.r.funct == `FN_MFHI);
						wbCtrl.hiloBusy = 1'b1;
					end
					`FN_MTHI, `FN_MTLO: begin
						wbCtrl.hiloWr = 1'b1;
						wbCtrl.hiloWrSel = (instr.r.funct == `FN_MTHI) ?
							decodePkg::hiloHi : decodePkg::hiloLo;
						wbCtrl.hiloBusy = 1'b1;
					end
					`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
						wbCtrl.hiloWr = 1'b1;
						wbCtrl.hiloWrSel = decodePkg::hiloMdu; // Both halves from the MDU
						wbCtrl.hiloBusy = 1'b1;
						wbCtrl.mduStart = 1'b1;
					end
					default: wbCtrl.rfWr = 1'b0;
				endcase
				case (instr.r.funct)
					`FN_MULT: wbCtrl.mduOp = decodePkg::mduMult;
					`FN_DIVU: wbCtrl.mduOp = decodePkg::mduDivu;
					`FN_DIV:  wbCtrl.mduOp = decodePkg::mduDiv;
					default:  wbCtrl.mduOp = decodePkg::mduMultu;
				endcase
			end
			`OP_REGIMM: begin
				// Only the AL forms link
				if (instr.i.rt == `RT_BLTZAL || instr.i.rt == `RT_BGEZAL ||
					instr.i.rt == `RT_BLTZALL || instr.i.rt == `RT_BGEZALL) begin
					wbCtrl.rfWr = 1'b1;
					wbCtrl.destSel = decodePkg::destLink;
					wbCtrl.resultSel = decodePkg::resLink;
				end
			end
			`OP_JAL: begin
				wbCtrl.rfWr = 1'b1;
				wbCtrl.destSel = decodePkg::destLink;
				wbCtrl.resultSel = decodePkg::resLink;
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI:
				wbCtrl.rfWr = 1'b1;
			`OP_LUI: begin
				wbCtrl.rfWr = 1'b1;
				wbCtrl.resultSel = decodePkg::resLui;
			end
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				wbCtrl.rfWr = 1'b1;
				wbCtrl.resultSel = decodePkg::resMem;
			end
			default: wbCtrl.rfWr = 1'b0;
		endcase
	end

endmodule

// File: source/memDecoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module memDecoder (
	input  decodePkg::instrWord_t instr,
	output decodePkg::memCtrl_t   memCtrl
);

	always_comb begin
		memCtrl.rd = 1'b0;
		memCtrl.wr = 1'b0;
		case (instr.i.opcode)
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: memCtrl.rd = 1'b1;
			`OP_SB, `OP_SH, `OP_SW:                   memCtrl.wr = 1'b1;
			default:                                  memCtrl.rd = 1'b0;
		endcase
	end

	// Size and signedness, word when no access
	always_comb begin
		case (instr.i.opcode)
			`OP_SB:  memCtrl.memSel = decodePkg::memSb;
			`OP_SH:  memCtrl.memSel = decodePkg::memSh;
			`OP_SW:  memCtrl.memSel = decodePkg::memSw;
			`OP_LBU: memCtrl.memSel = decodePkg::memLbu;
			`OP_LB:  memCtrl.memSel = decodePkg::memLb;
			`OP_LHU: memCtrl.memSel = decodePkg::memLhu;
			`OP_LH:  memCtrl.memSel = decodePkg::memLh;
			default: memCtrl.memSel = decodePkg::memLw;
		endcase
	end

endmodule

// File: source/branchDecoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module branchDecoder (
	input  decodePkg::instrWord_t   instr,
	output decodePkg::branchClass_t branchClass,
	output logic                    isBranch,
	output decodePkg::predHint_t    predHint
);

	logic linkCall; // JAL or an AL branch
	logic retJump;  // JR through the link register

	always_comb begin
		branchClass.cond = decodePkg::brNone;
		branchClass.jump = decodePkg::jumpNone;
		linkCall = 1'b0;
		retJump = 1'b0;
		case (instr.i.opcode)
			`OP_BEQ, `OP_BEQL: branchClass.cond = decodePkg::brEq;
			`OP_BNE, `OP_BNEL: branchClass.cond = decodePkg::brNe;
			`OP_BLEZ:          branchClass.cond = decodePkg::brLez;
			`OP_BGTZ:          branchClass.cond = decodePkg::brGtz;
			`OP_BLEZL: begin
				if (instr.i.rt == '0)
					branchClass.cond = decodePkg::brLez;
			end
			`OP_BGTZL: begin
				if (instr.i.rt == '0)
					branchClass.cond = decodePkg::brGtz;
			end
			`OP_REGIMM: begin
				case (instr.i.rt)
					`RT_BLTZ, `RT_BLTZL, `RT_BLTZAL, `RT_BLTZALL:
						branchClass.cond = decodePkg::brLtz;
					`RT_BGEZ, `RT_BGEZL, `RT_BGEZAL, `RT_BGEZALL:
						branchClass.cond = decodePkg::brGez;
					default: branchClass.cond = decodePkg::brNone;
				endcase
				linkCall = instr.i.rt[4] && (branchClass.cond != decodePkg::brNone);
			end
			`OP_J: branchClass.jump = decodePkg::jumpDirect;
			`OP_JAL: begin
				branchClass.jump = decodePkg::jumpDirect;
				linkCall = 1'b1;
			end
			`OP_SPECIAL: begin
				if (instr.r.funct == `FN_JR || instr.r.funct == `FN_JALR)
					branchClass.jump = decodePkg::jumpReg;
				retJump = (instr.r.funct == `FN_JR) && (instr.r.rs == `LINK_REG);
			end
			default: branchClass.cond = decodePkg::brNone;
		endcase
		// Likely opcodes are 0101xx, likely REGIMM forms have rt bit 1 set
		branchClass.likely = (branchClass.cond != decodePkg::brNone) &&
			((instr.i.opcode[5:2] == 4'b0101) ||
			((instr.i.opcode == `OP_REGIMM) && instr.i.rt[1]));
	end

	assign isBranch = (branchClass.cond != decodePkg::brNone) ||
		(branchClass.jump != decodePkg::jumpNone);

	assign predHint = retJump  ? decodePkg::predRet :
	                  linkCall ? decodePkg::predCall :
	                  isBranch ? decodePkg::predOther : decodePkg::predNone;

endmodule

// File: source/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
	input  decodePkg::branchClass_t branchClass,
	input  decodePkg::cmpResult_t   cmp,
	output decodePkg::npcOp_t       npcOp,
	output logic                    delaySlotKill
);

	logic condHolds;
	logic isCond;

	assign isCond = (branchClass.cond != decodePkg::brNone);

	always_comb begin
		case (branchClass.cond)
			decodePkg::brEq:  condHolds = cmp.equal;
			decodePkg::brNe:  condHolds = !cmp.equal;
			decodePkg::brGez: condHolds = !cmp.negative;
			decodePkg::brLtz: condHolds = cmp.negative;
			decodePkg::brLez: condHolds = !cmp.positive;
			decodePkg::brGtz: condHolds = cmp.positive;
			default:          condHolds = 1'b0;
		endcase
	end

	always_comb begin
		if (isCond)
			npcOp = condHolds ? decodePkg::npcBranch : decodePkg::npcSeq;
		else begin
			case (branchClass.jump)
				decodePkg::jumpDirect: npcOp = decodePkg::npcJump;
				decodePkg::jumpReg:    npcOp = decodePkg::npcJumpReg;
				default:               npcOp = decodePkg::npcSeq;
			endcase
		end
	end

	// Not-taken likely branch nullifies its delay slot
	assign delaySlotKill = branchClass.likely && isCond && !condHolds;

endmodule

// File: source/exceptionDetect.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module exceptionDetect (
	input  logic                  clk,
	input  logic                  rst,
	input  decodePkg::instrWord_t instr,
	input  decodePkg::wbCtrl_t    wbCtrl,
	input  decodePkg::memCtrl_t   memCtrl,
	input  logic                  isBranch,
	input  decodePkg::excInfo_t   fetchExc,
	input  logic                  ifFlush,
	output decodePkg::excInfo_t   exc
);

	logic recentReset; // High until the first edge with rst released
	logic isBreak;
	logic isSyscall;
	logic recognized;

	always_ff @(posedge clk) begin
		if (!rst)
			recentReset <= 1'b1;
		else
			recentReset <= 1'b0;
	end

	assign isBreak = (instr.r.opcode == `OP_SPECIAL) && (instr.r.funct == `FN_BREAK);
	assign isSyscall = (instr.r.opcode == `OP_SPECIAL) && (instr.r.funct == `FN_SYSCALL);

	// Loads are covered by rfWr
	assign recognized = wbCtrl.rfWr || wbCtrl.hiloWr || memCtrl.wr || isBranch ||
		isBreak || isSyscall;

	always_comb begin
		exc.valid = 1'b1;
		if (fetchExc.valid)
			exc.code = fetchExc.code; // Upstream exception wins
		else if (!recognized && !ifFlush && !recentReset)
			exc.code = `EXC_RI;
		else if (isBreak)
			exc.code = `EXC_BP;
		else if (isSyscall)
			exc.code = `EXC_SYS;
		else begin
			exc.valid = 1'b0;
			exc.code = '0;
		end
	end

endmodule

// File: source/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic                  clk,
	input  logic                  rst,
	input  decodePkg::instrWord_t instr,
	input  decodePkg::cmpResult_t cmp,
	input  decodePkg::excInfo_t   fetchExc,
	input  logic                  ifFlush, // Decode slot holds a bubble
	output decodePkg::aluCtrl_t   aluCtrl,
	output decodePkg::wbCtrl_t    wbCtrl,
	output decodePkg::memCtrl_t   memCtrl,
	output logic                  isBranch,
	output decodePkg::predHint_t  predHint,
	output decodePkg::npcOp_t     npcOp,
	output logic                  delaySlotKill,
	output decodePkg::excInfo_t   exc
);

	decodePkg::branchClass_t branchClass;

	aluDecoder i_aluDecoder (
		.instr   (instr),
		.aluCtrl (aluCtrl)
	);

	resultDecoder i_resultDecoder (
		.instr  (instr),
		.wbCtrl (wbCtrl)
	);

	memDecoder i_memDecoder (
		.instr   (instr),
		.memCtrl (memCtrl)
	);

	branchDecoder i_branchDecoder (
		.instr       (instr),
		.branchClass (branchClass),
		.isBranch    (isBranch),
		.predHint    (predHint)
	);

	branchResolver i_branchResolver (
		.branchClass   (branchClass),
		.cmp           (cmp),
		.npcOp         (npcOp),
		.delaySlotKill (delaySlotKill)
	);

	exceptionDetect i_exceptionDetect (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.wbCtrl   (wbCtrl),
		.memCtrl  (memCtrl),
		.isBranch (isBranch),
		.fetchExc (fetchExc),
		.ifFlush  (ifFlush),
		.exc      (exc)
	);

endmodule

// File: testbench/instrDecodeTb.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module instrDecodeTb;

	logic                  clk = 1'b0;
	logic                  rst;
	decodePkg::instrWord_t instr;
	decodePkg::cmpResult_t cmp;
	decodePkg::excInfo_t   fetchExc;
	logic                  ifFlush;
	decodePkg::aluCtrl_t   aluCtrl;
	decodePkg::wbCtrl_t    wbCtrl;
	decodePkg::memCtrl_t   memCtrl;
	logic                  isBranch;
	decodePkg::predHint_t  predHint;
	decodePkg::npcOp_t     npcOp;
	logic                  delaySlotKill;
	decodePkg::excInfo_t   exc;

	logic [31:0] lfsrState = 32'h5b0997ee;

	instrDecode i_instrDecode (
		.clk           (clk),
		.rst           (rst),
		.instr         (instr),
		.cmp           (cmp),
		.fetchExc      (fetchExc),
		.ifFlush       (ifFlush),
		.aluCtrl       (aluCtrl),
		.wbCtrl        (wbCtrl),
		.memCtrl       (memCtrl),
		.isBranch      (isBranch),
		.predHint      (predHint),
		.npcOp         (npcOp),
		.delaySlotKill (delaySlotKill),
		.exc           (exc)
	);

	always #5 clk = ~clk;

	// Taps 32, 22, 2, 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic decodePkg::instrWord_t makeR(input logic [`FUNCT_W-1:0] funct);
		decodePkg::instrWord_t w;
		logic [31:0] rnd;
		rnd = randBits(20);
		w.r.opcode = `OP_SPECIAL;
		{w.r.rs, w.r.rt, w.r.rd, w.r.shamt} = rnd[19:0];
		w.r.funct = funct;
		return w;
	endfunction

	function automatic decodePkg::instrWord_t makeI(input logic [`OP_W-1:0] op);
		decodePkg::instrWord_t w;
		logic [31:0] rnd;
		rnd = randBits(26);
		w.i.opcode = op;
		{w.i.rs, w.i.rt, w.i.imm16} = rnd[25:0];
		return w;
	endfunction

	function automatic decodePkg::instrWord_t makeRegimm(input logic [`REG_W-1:0] rtCode);
		decodePkg::instrWord_t w;
		logic [31:0] rnd;
		rnd = randBits(21);
		w.i.opcode = `OP_REGIMM;
		w.i.rt = rtCode;
		{w.i.rs, w.i.imm16} = rnd[20:0];
		return w;
	endfunction

	// Branch condition against the comparison bits
	function automatic logic branchTaken(input decodePkg::brCond_t cond,
		input decodePkg::cmpResult_t c);
		case (cond)
			decodePkg::brEq:  return c.equal;
			decodePkg::brNe:  return !c.equal;
			decodePkg::brGez: return !c.negative;
			decodePkg::brLtz: return c.negative;
			decodePkg::brLez: return !c.positive;
			decodePkg::brGtz: return c.positive;
			default:          return 1'b0;
		endcase
	endfunction

	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Inputs change 1 ns after the edge, outputs sampled 3 ns later
	task automatic drive(input decodePkg::instrWord_t w, input decodePkg::cmpResult_t c,
		input decodePkg::excInfo_t fe, input logic flush);
		@(posedge clk);
		#1;
		instr = w;
		cmp = c;
		fetchExc = fe;
		ifFlush = flush;
		#3;
	endtask

	task automatic checkAlu(input string name, input decodePkg::instrWord_t w,
		input decodePkg::aluOp_t op, input logic byShamt, input decodePkg::extOp_t ext,
		input logic imm);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " aluCtrl.aluOp"}, 32'(aluCtrl.aluOp), 32'(op));
		checkEq({name, " aluCtrl.shiftByShamt"}, 32'(aluCtrl.shiftByShamt), 32'(byShamt));
		checkEq({name, " aluCtrl.useImm"}, 32'(aluCtrl.useImm), 32'(imm));
		if (imm)
			checkEq({name, " aluCtrl.extOp"}, 32'(aluCtrl.extOp), 32'(ext));
	endtask

	task automatic aluTests();
		checkAlu("ADD", makeR(`FN_ADD), decodePkg::aluAdd, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("ADDU", makeR(`FN_ADDU), decodePkg::aluAddu, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("SUB", makeR(`FN_SUB), decodePkg::aluSub, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("AND", makeR(`FN_AND), decodePkg::aluAnd, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("OR", makeR(`FN_OR), decodePkg::aluOr, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("NOR", makeR(`FN_NOR), decodePkg::aluNor, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("XOR", makeR(`FN_XOR), decodePkg::aluXor, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("SLL", makeR(`FN_SLL), decodePkg::aluSll, 1'b1, decodePkg::extZero, 1'b0);
		checkAlu("SRAV", makeR(`FN_SRAV), decodePkg::aluSra, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("SLT", makeR(`FN_SLT), decodePkg::aluSlt, 1'b0, decodePkg::extZero, 1'b0);
		checkAlu("ADDI", makeI(`OP_ADDI), decodePkg::aluAdd, 1'b0, decodePkg::extSign, 1'b1);
		checkAlu("ORI", makeI(`OP_ORI), decodePkg::aluOr, 1'b0, decodePkg::extZero, 1'b1);
		checkAlu("SLTIU", makeI(`OP_SLTIU), decodePkg::aluSltu, 1'b0, decodePkg::extSign, 1'b1);
		checkAlu("LUI", makeI(`OP_LUI), decodePkg::aluNone, 1'b0, decodePkg::extUpper, 1'b1);
	endtask

	task automatic checkWb(input string name, input decodePkg::instrWord_t w, input logic wr,
		input decodePkg::destSel_t dest, input decodePkg::resultSel_t res);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " wbCtrl.rfWr"}, 32'(wbCtrl.rfWr), 32'(wr));
		checkEq({name, " wbCtrl.hiloBusy"}, 32'(wbCtrl.hiloBusy), 0); // No HI/LO access here
		if (wr) begin
			checkEq({name, " wbCtrl.destSel"}, 32'(wbCtrl.destSel), 32'(dest));
			checkEq({name, " wbCtrl.resultSel"}, 32'(wbCtrl.resultSel), 32'(res));
		end
	endtask

	task automatic wbTests();
		checkWb("ADD", makeR(`FN_ADD), 1'b1, decodePkg::destRd, decodePkg::resAlu);
		checkWb("SRL", makeR(`FN_SRL), 1'b1, decodePkg::destRd, decodePkg::resAlu);
		checkWb("ADDIU", makeI(`OP_ADDIU), 1'b1, decodePkg::destRt, decodePkg::resAlu);
		checkWb("LUI", makeI(`OP_LUI), 1'b1, decodePkg::destRt, decodePkg::resLui);
		checkWb("LW", makeI(`OP_LW), 1'b1, decodePkg::destRt, decodePkg::resMem);
		checkWb("LBU", makeI(`OP_LBU), 1'b1, decodePkg::destRt, decodePkg::resMem);
		checkWb("JAL", makeI(`OP_JAL), 1'b1, decodePkg::destLink, decodePkg::resLink);
		checkWb("JALR", makeR(`FN_JALR), 1'b1, decodePkg::destRd, decodePkg::resLink);
		checkWb("BGEZAL", makeRegimm(`RT_BGEZAL), 1'b1, decodePkg::destLink, decodePkg::resLink);
		checkWb("SW", makeI(`OP_SW), 1'b0, decodePkg::destRt, decodePkg::resAlu);
		checkWb("BEQ", makeI(`OP_BEQ), 1'b0, decodePkg::destRt, decodePkg::resAlu);
		checkWb("BGEZ", makeRegimm(`RT_BGEZ), 1'b0, decodePkg::destRt, decodePkg::resAlu);
		checkWb("J", makeI(`OP_J), 1'b0, decodePkg::destRt, decodePkg::resAlu);
	endtask

	task automatic checkMem(input string name, input decodePkg::instrWord_t w, input logic rd,
		input logic wr, input decodePkg::memSel_t sel);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " memCtrl.rd"}, 32'(memCtrl.rd), 32'(rd));
		checkEq({name, " memCtrl.wr"}, 32'(memCtrl.wr), 32'(wr));
		checkEq({name, " memCtrl.memSel"}, 32'(memCtrl.memSel), 32'(sel));
	endtask

	task automatic checkHiloWrite(input string name, input decodePkg::instrWord_t w,
		input decodePkg::hiloWrSel_t sel, input logic start, input decodePkg::mduOp_t op);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " wbCtrl.rfWr"}, 32'(wbCtrl.rfWr), 0);
		checkEq({name, " wbCtrl.hiloWr"}, 32'(wbCtrl.hiloWr), 1);
		checkEq({name, " wbCtrl.hiloWrSel"}, 32'(wbCtrl.hiloWrSel), 32'(sel));
		checkEq({name, " wbCtrl.hiloBusy"}, 32'(wbCtrl.hiloBusy), 1);
		checkEq({name, " wbCtrl.mduStart"}, 32'(wbCtrl.mduStart), 32'(start));
		if (start)
			checkEq({name, " wbCtrl.mduOp"}, 32'(wbCtrl.mduOp), 32'(op));
	endtask

	task automatic checkHiloRead(input string name, input decodePkg::instrWord_t w,
		input logic hi);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " wbCtrl.rfWr"}, 32'(wbCtrl.rfWr), 1);
		checkEq({name, " wbCtrl.destSel"}, 32'(wbCtrl.destSel), 32'(decodePkg::destRd));
		checkEq({name, " wbCtrl.resultSel"}, 32'(wbCtrl.resultSel), 32'(decodePkg::resHilo));
		checkEq({name, " wbCtrl.hiloRdHi"}, 32'(wbCtrl.hiloRdHi), 32'(hi));
		checkEq({name, " wbCtrl.hiloBusy"}, 32'(wbCtrl.hiloBusy), 1);
		checkEq({name, " wbCtrl.hiloWr"}, 32'(wbCtrl.hiloWr), 0);
	endtask

	task automatic memHiloTests();
		checkMem("LB", makeI(`OP_LB), 1'b1, 1'b0, decodePkg::memLb);
		checkMem("LBU", makeI(`OP_LBU), 1'b1, 1'b0, decodePkg::memLbu);
		checkMem("LH", makeI(`OP_LH), 1'b1, 1'b0, decodePkg::memLh);
		checkMem("LHU", makeI(`OP_LHU), 1'b1, 1'b0, decodePkg::memLhu);
		checkMem("LW", makeI(`OP_LW), 1'b1, 1'b0, decodePkg::memLw);
		checkMem("SB", makeI(`OP_SB), 1'b0, 1'b1, decodePkg::memSb);
		checkMem("SH", makeI(`OP_SH), 1'b0, 1'b1, decodePkg::memSh);
		checkMem("SW", makeI(`OP_SW), 1'b0, 1'b1, decodePkg::memSw);
		checkMem("ADD", makeR(`FN_ADD), 1'b0, 1'b0, decodePkg::memLw); // No access reports lw
		checkHiloWrite("MULT", makeR(`FN_MULT), decodePkg::hiloMdu, 1'b1, decodePkg::mduMult);
		checkHiloWrite("MULTU", makeR(`FN_MULTU), decodePkg::hiloMdu, 1'b1, decodePkg::mduMultu);
		checkHiloWrite("DIV", makeR(`FN_DIV), decodePkg::hiloMdu, 1'b1, decodePkg::mduDiv);
		checkHiloWrite("DIVU", makeR(`FN_DIVU), decodePkg::hiloMdu, 1'b1, decodePkg::mduDivu);
		checkHiloWrite("MTHI", makeR(`FN_MTHI), decodePkg::hiloHi, 1'b0, decodePkg::mduMultu);
		checkHiloWrite("MTLO", makeR(`FN_MTLO), decodePkg::hiloLo, 1'b0, decodePkg::mduMultu);
		checkHiloRead("MFHI", makeR(`FN_MFHI), 1'b1);
		checkHiloRead("MFLO", makeR(`FN_MFLO), 1'b0);
	endtask

	// All six legal cmp codes, negative and positive never both set
	task automatic checkBranch(input string name, input decodePkg::instrWord_t w,
		input decodePkg::brCond_t cond, input logic likely, input decodePkg::predHint_t hint);
		decodePkg::cmpResult_t c;
		logic taken;
		int eq;
		int sgn;
		for (eq = 0; eq < 2; eq++) begin
			for (sgn = 0; sgn < 3; sgn++) begin
				c.equal = eq[0];
				c.negative = (sgn == 0);
				c.positive = (sgn == 2);
				taken = branchTaken(cond, c);
				drive(w, c, '0, 1'b0);
				checkEq({name, " isBranch"}, 32'(isBranch), 1);
				checkEq({name, " npcOp"}, 32'(npcOp),
					taken ? 32'(decodePkg::npcBranch) : 32'(decodePkg::npcSeq));
				checkEq({name, " delaySlotKill"}, 32'(delaySlotKill), 32'(likely && !taken));
				checkEq({name, " predHint"}, 32'(predHint), 32'(hint));
			end
		end
	endtask

	task automatic checkJump(input string name, input decodePkg::instrWord_t w,
		input logic branch, input decodePkg::npcOp_t npc, input decodePkg::predHint_t hint);
		drive(w, '0, '0, 1'b0);
		checkEq({name, " isBranch"}, 32'(isBranch), 32'(branch));
		checkEq({name, " npcOp"}, 32'(npcOp), 32'(npc));
		checkEq({name, " delaySlotKill"}, 32'(delaySlotKill), 0);
		checkEq({name, " predHint"}, 32'(predHint), 32'(hint));
	endtask

	task automatic branchTests();
		decodePkg::instrWord_t w;
		checkBranch("BEQ", makeI(`OP_BEQ), decodePkg::brEq, 1'b0, decodePkg::predOther);
		checkBranch("BNE", makeI(`OP_BNE), decodePkg::brNe, 1'b0, decodePkg::predOther);
		checkBranch("BLEZ", makeI(`OP_BLEZ), decodePkg::brLez, 1'b0, decodePkg::predOther);
		checkBranch("BGTZ", makeI(`OP_BGTZ), decodePkg::brGtz, 1'b0, decodePkg::predOther);
		checkBranch("BEQL", makeI(`OP_BEQL), decodePkg::brEq, 1'b1, decodePkg::predOther);
		checkBranch("BNEL", makeI(`OP_BNEL), decodePkg::brNe, 1'b1, decodePkg::predOther);
		w = makeI(`OP_BLEZL);
		w.i.rt = '0;
		checkBranch("BLEZL", w, decodePkg::brLez, 1'b1, decodePkg::predOther);
		w = makeI(`OP_BGTZL);
		w.i.rt = '0;
		checkBranch("BGTZL", w, decodePkg::brGtz, 1'b1, decodePkg::predOther);
		w = makeI(`OP_BLEZL);
		w.i.rt[0] = 1'b1; // Nonzero rt is no branch
		checkJump("BLEZL rt!=0", w, 1'b0, decodePkg::npcSeq, decodePkg::predNone);
		checkBranch("BLTZ", makeRegimm(`RT_BLTZ), decodePkg::brLtz, 1'b0, decodePkg::predOther);
		checkBranch("BGEZ", makeRegimm(`RT_BGEZ), decodePkg::brGez, 1'b0, decodePkg::predOther);
		checkBranch("BLTZL", makeRegimm(`RT_BLTZL), decodePkg::brLtz, 1'b1, decodePkg::predOther);
		checkBranch("BGEZL", makeRegimm(`RT_BGEZL), decodePkg::brGez, 1'b1, decodePkg::predOther);
		checkBranch("BLTZAL", makeRegimm(`RT_BLTZAL), decodePkg::brLtz, 1'b0, decodePkg::predCall);
		checkBranch("BGEZAL", makeRegimm(`RT_BGEZAL), decodePkg::brGez, 1'b0, decodePkg::predCall);
		checkBranch("BLTZALL", makeRegimm(`RT_BLTZALL), decodePkg::brLtz, 1'b1,
			decodePkg::predCall);
		checkBranch("BGEZALL", makeRegimm(`RT_BGEZALL), decodePkg::brGez, 1'b1,
			decodePkg::predCall);
		checkJump("J", makeI(`OP_J), 1'b1, decodePkg::npcJump, decodePkg::predOther);
		checkJump("JAL", makeI(`OP_JAL), 1'b1, decodePkg::npcJump, decodePkg::predCall);
		w = makeR(`FN_JR);
		w.r.rs = `LINK_REG;
		checkJump("JR 31", w, 1'b1, decodePkg::npcJumpReg, decodePkg::predRet);
		w = makeR(`FN_JR);
		w.r.rs[4] = 1'b0; // Any register other than 31
		checkJump("JR", w, 1'b1, decodePkg::npcJumpReg, decodePkg::predOther);
		checkJump("JALR", makeR(`FN_JALR), 1'b1, decodePkg::npcJumpReg, decodePkg::predOther);
		checkJump("ADD", makeR(`FN_ADD), 1'b0, decodePkg::npcSeq, decodePkg::predNone);
	endtask

	task automatic checkExc(input string name, input decodePkg::instrWord_t w,
		input decodePkg::excInfo_t fe, input logic flush, input logic valid,
		input logic [`EXC_CODE_W-1:0] code);
		drive(w, '0, fe, flush);
		checkEq({name, " exc.valid"}, 32'(exc.valid), 32'(valid));
		checkEq({name, " exc.code"}, 32'(exc.code), 32'(code));
	endtask

	task automatic exceptionTests();
		decodePkg::excInfo_t none;
		decodePkg::excInfo_t upstream;
		none = '0;
		upstream = {1'b1, 5'd4}; // Address error from fetch
		checkExc("COP0", makeI(6'b010000), none, 1'b0, 1'b1, `EXC_RI);
		checkExc("SPECIAL2", makeI(6'b011100), none, 1'b0, 1'b1, `EXC_RI);
		checkExc("MOVZ", makeR(6'b001010), none, 1'b0, 1'b1, `EXC_RI);
		checkExc("COP0 flushed", makeI(6'b010000), none, 1'b1, 1'b0, 5'd0);
		checkExc("BREAK", makeR(`FN_BREAK), none, 1'b0, 1'b1, `EXC_BP);
		checkExc("SYSCALL", makeR(`FN_SYSCALL), none, 1'b0, 1'b1, `EXC_SYS);
		checkExc("ADD", makeR(`FN_ADD), none, 1'b0, 1'b0, 5'd0);
		checkExc("SW", makeI(`OP_SW), none, 1'b0, 1'b0, 5'd0);
		checkExc("MTLO", makeR(`FN_MTLO), none, 1'b0, 1'b0, 5'd0);
		checkExc("BEQ", makeI(`OP_BEQ), none, 1'b0, 1'b0, 5'd0);
		checkExc("COP0 fetchExc", makeI(6'b010000), upstream, 1'b0, 1'b1, 5'd4);
		checkExc("BREAK fetchExc", makeR(`FN_BREAK), upstream, 1'b0, 1'b1, 5'd4);
		checkExc("SYSCALL fetchExc", makeR(`FN_SYSCALL), upstream, 1'b1, 1'b1, 5'd4);
	endtask

	task automatic resetSuppressionTest();
		int cycles;
		drive(makeI(6'b010000), '0, '0, 1'b0);
		@(posedge clk);
		#1;
		rst = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#4;
			checkEq("exc.valid in reset", 32'(exc.valid), 0);
		end
		@(posedge clk);
		#1;
		rst = 1'b1;
		#3;
		checkEq("exc.valid after release", 32'(exc.valid), 0);
		cycles = 0;
		while (!exc.valid && cycles < 8) begin
			@(posedge clk);
			#4;
			cycles++;
		end
		if (!exc.valid) begin
			$display("Timed out waiting for the reserved-instruction exception after reset");
			$display("Test FAILED");
			$fatal(1, "no exception after reset");
		end
		checkEq("cycles to exc.valid", cycles, 1);
		checkEq("exc.code after reset", 32'(exc.code), 32'(`EXC_RI));
	endtask

	initial begin
		rst = 1'b0;
		instr = '0;
		cmp = '0;
		fetchExc = '0;
		ifFlush = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;
		aluTests();
		wbTests();
		memHiloTests();
		branchTests();
		exceptionTests();
		resetSuppressionTest();
		$display("Test OK");
		$finish;
	end

endmodule

// File: sim.f
+incdir+source
source/decodePkg.sv
source/aluDecoder.sv
source/resultDecoder.sv
source/memDecoder.sv
source/branchDecoder.sv
source/branchResolver.sv
source/exceptionDetect.sv
source/instrDecode.sv
testbench/instrDecodeTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module instrDecodeTb -o instrDecodeSim \
	&& ./obj_dir/instrDecodeSim | grep "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
